/* conv_fmt_pkg.sv */
package conv_fmt_pkg;

  // input pixel element, signed.
  localparam int DATA_W      = 8;
  localparam int DATA_FRAC   = 3;

  // weight, signed.
  localparam int WEIGHT_W    = 8;
  localparam int WEIGHT_FRAC = 4;

  // bias, signed.
  localparam int BIAS_W      = 8;
  localparam int BIAS_FRAC   = 4;

  // rounded output, signed.
  localparam int OUT_W       = 8;
  localparam int OUT_FRAC    = 4;

endpackage

/* conv_ctrl_pkg.sv */
package conv_ctrl_pkg;

  typedef enum logic {
    SW_LOAD, // collecting the image.
    SW_EMIT  // stepping through the windows.
  } sw_state_e;

  typedef enum logic {
    CORE_ACC,  // hold register empty.
    CORE_HOLD  // result waiting on data_out_ready.
  } core_state_e;

endpackage

/* sliding_window.sv */
`timescale 1ns/1ps
module sliding_window #(
  parameter int DATA_W      = 8,
  parameter int IN_X        = 4,
  parameter int IN_Y        = 3,
  parameter int IN_C        = 4,
  parameter int UNROLL_IN_C = 2,
  parameter int KERNEL_X    = 3,
  parameter int KERNEL_Y    = 3,
  parameter int PADDING_X   = 1,
  parameter int PADDING_Y   = 1
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [UNROLL_IN_C*DATA_W-1:0] data_in,
  input  logic                          data_in_valid,
  output logic                          data_in_ready,
  output logic [UNROLL_IN_C*DATA_W-1:0] data_out [KERNEL_X*KERNEL_Y-1:0],
  output logic                          data_out_valid,
  input  logic                          data_out_ready
);
  import conv_ctrl_pkg::*;

  localparam int BEAT_W    = UNROLL_IN_C * DATA_W;
  localparam int OUT_X     = IN_X - KERNEL_X + 2 * PADDING_X + 1;
  localparam int OUT_Y     = IN_Y - KERNEL_Y + 2 * PADDING_Y + 1;
  localparam int CH_GROUPS = IN_C / UNROLL_IN_C;
  localparam int BEATS     = IN_X * IN_Y * CH_GROUPS;
  localparam int LD_W      = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int OX_W      = (OUT_X > 1) ? $clog2(OUT_X) : 1;
  localparam int OY_W      = (OUT_Y > 1) ? $clog2(OUT_Y) : 1;
  localparam int G_W       = (CH_GROUPS > 1) ? $clog2(CH_GROUPS) : 1;

  sw_state_e         state_q;
  logic [LD_W-1:0]   ld_cnt_q;
  logic [OX_W-1:0]   ox_q;
  logic [OY_W-1:0]   oy_q;
  logic [G_W-1:0]    g_q;
  logic [BEAT_W-1:0] img_q [BEATS-1:0];
  logic              load;
  logic              emit;
  logic              last_beat;
  logic              last_g;
  logic              last_ox;
  logic              last_oy;

  assign data_in_ready  = (state_q == SW_LOAD);
  assign data_out_valid = (state_q == SW_EMIT);
  assign load           = data_in_valid & data_in_ready;
  assign emit           = data_out_valid & data_out_ready;

  assign last_beat = (ld_cnt_q == LD_W'(BEATS - 1));
  assign last_g    = (g_q == G_W'(CH_GROUPS - 1));
  assign last_ox   = (ox_q == OX_W'(OUT_X - 1));
  assign last_oy   = (oy_q == OY_W'(OUT_Y - 1));

  always_ff @(posedge clk) begin
    if (load) begin
      img_q[ld_cnt_q] <= data_in;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= SW_LOAD;
      ld_cnt_q <= '0;
      ox_q     <= '0;
      oy_q     <= '0;
      g_q      <= '0;
    end else begin
      case (state_q)
        SW_LOAD: begin
          if (load) begin
            if (last_beat) begin
              ld_cnt_q <= '0;
              state_q  <= SW_EMIT;
            end else begin
              ld_cnt_q <= ld_cnt_q + 1'b1;
            end
          end
        end
        SW_EMIT: begin
          if (emit) begin
            if (!last_g) begin
              g_q <= g_q + 1'b1;
            end else begin
              g_q <= '0;
              if (!last_ox) begin
                ox_q <= ox_q + 1'b1;
              end else begin
                ox_q <= '0;
                if (!last_oy) begin
                  oy_q <= oy_q + 1'b1;
                end else begin
                  oy_q    <= '0;
                  state_q <= SW_LOAD; // image done, take the next one.
                end
              end
            end
          end
        end
        default: state_q <= SW_LOAD;
      endcase
    end
  end

  // window taps, zero where the tap falls in the padding.
  always_comb begin
    int iy;
    int ix;
    for (int ky = 0; ky < KERNEL_Y; ky++) begin
      for (int kx = 0; kx < KERNEL_X; kx++) begin
        iy = int'(oy_q) + ky - PADDING_Y;
        ix = int'(ox_q) + kx - PADDING_X;
        if (iy < 0 || iy >= IN_Y || ix < 0 || ix >= IN_X) begin
          data_out[ky*KERNEL_X+kx] = '0;
        end else begin
          data_out[ky*KERNEL_X+kx] = img_q[(iy*IN_X+ix)*CH_GROUPS+int'(g_q)];
        end
      end
    end
  end

endmodule

/* roller.sv */
`timescale 1ns/1ps
module roller #(
  parameter int DATA_W   = 8,
  parameter int NUM      = 18,
  parameter int ROLL_NUM = 6
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [DATA_W-1:0] data_in [NUM-1:0],
  input  logic              data_in_valid,
  output logic              data_in_ready,
  output logic [DATA_W-1:0] data_out [ROLL_NUM-1:0],
  output logic              data_out_valid,
  input  logic              data_out_ready
);

  localparam int CHUNKS = NUM / ROLL_NUM;
  localparam int CNT_W  = (CHUNKS > 1) ? $clog2(CHUNKS) : 1;

  logic [DATA_W-1:0] win_q [NUM-1:0];
  logic [CNT_W-1:0]  chunk_q;
  logic              full_q;
  logic              last_chunk;

  assign data_in_ready  = ~full_q;
  assign data_out_valid = full_q;
  assign last_chunk     = (chunk_q == CNT_W'(CHUNKS - 1));

  always_ff @(posedge clk) begin
    if (data_in_valid && data_in_ready) begin
      win_q <= data_in;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q  <= 1'b0;
      chunk_q <= '0;
    end else if (data_in_valid && data_in_ready) begin
      full_q  <= 1'b1;
      chunk_q <= '0;
    end else if (data_out_valid && data_out_ready) begin
      if (last_chunk) begin
        full_q  <= 1'b0; // free for the next window.
        chunk_q <= '0;
      end else begin
        chunk_q <= chunk_q + 1'b1;
      end
    end
  end

  always_comb begin
    for (int e = 0; e < ROLL_NUM; e++) begin
      data_out[e] = win_q[int'(chunk_q)*ROLL_NUM+e];
    end
  end

endmodule

/* conv_compute_core.sv */
`timescale 1ns/1ps
module conv_compute_core #(
  parameter int DATA_W            = 8,
  parameter int DATA_FRAC         = 3,
  parameter int WEIGHT_W          = 8,
  parameter int WEIGHT_FRAC       = 4,
  parameter int BIAS_W            = 8,
  parameter int BIAS_FRAC         = 4,
  parameter int IN_C              = 4,
  parameter int UNROLL_IN_C       = 2,
  parameter int KERNEL_X          = 3,
  parameter int KERNEL_Y          = 3,
  parameter int UNROLL_KERNEL_OUT = 6,
  parameter int UNROLL_OUT_C      = 2,
  parameter int HAS_BIAS          = 1,
  localparam int ACC_W = DATA_W + WEIGHT_W + $clog2(KERNEL_X * KERNEL_Y * IN_C) + 1
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [DATA_W-1:0]   data_in [UNROLL_KERNEL_OUT-1:0],
  input  logic                data_in_valid,
  output logic                data_in_ready,
  input  logic [WEIGHT_W-1:0] weight [UNROLL_OUT_C*UNROLL_KERNEL_OUT-1:0],
  input  logic                weight_valid,
  output logic                weight_ready,
  input  logic [BIAS_W-1:0]   bias [UNROLL_OUT_C-1:0],
  input  logic                bias_valid,
  output logic                bias_ready,
  output logic [ACC_W-1:0]    data_out [UNROLL_OUT_C-1:0],
  output logic                data_out_valid,
  input  logic                data_out_ready
);
  import conv_ctrl_pkg::*;

  localparam int NUM        = KERNEL_X * KERNEL_Y * UNROLL_IN_C;
  localparam int CH_GROUPS  = IN_C / UNROLL_IN_C;
  localparam int BEATS      = (NUM / UNROLL_KERNEL_OUT) * CH_GROUPS;
  localparam int CNT_W      = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int BIAS_SHIFT = DATA_FRAC + WEIGHT_FRAC - BIAS_FRAC;

  core_state_e             state_q;
  logic [CNT_W-1:0]        beat_q;
  logic [ACC_W-1:0]        acc_q [UNROLL_OUT_C-1:0];
  logic [ACC_W-1:0]        hold_q [UNROLL_OUT_C-1:0];
  logic signed [ACC_W-1:0] dot [UNROLL_OUT_C-1:0];
  logic signed [ACC_W-1:0] bias_al [UNROLL_OUT_C-1:0];
  logic                    last_beat;
  logic                    stall;
  logic                    bias_ok;
  logic                    fire;

  assign last_beat = (beat_q == CNT_W'(BEATS - 1));
  // the last beat waits while the previous result is still held.
  assign stall     = last_beat & (state_q == CORE_HOLD) & ~data_out_ready;
  assign bias_ok   = (HAS_BIAS == 0) | ~last_beat | bias_valid;

  assign data_in_ready = weight_valid & bias_ok & ~stall;
  assign weight_ready  = data_in_valid & bias_ok & ~stall;
  assign bias_ready    = (HAS_BIAS != 0) & last_beat & data_in_valid & weight_valid & ~stall;
  assign fire          = data_in_valid & weight_valid & bias_ok & ~stall;

  assign data_out       = hold_q;
  assign data_out_valid = (state_q == CORE_HOLD);

  always_comb begin
    logic signed [DATA_W+WEIGHT_W-1:0] prod;
    for (int o = 0; o < UNROLL_OUT_C; o++) begin
      dot[o] = '0;
      for (int e = 0; e < UNROLL_KERNEL_OUT; e++) begin
        prod   = $signed(data_in[e]) * $signed(weight[o*UNROLL_KERNEL_OUT+e]);
        dot[o] = dot[o] + prod;
      end
      if (HAS_BIAS != 0) begin
        bias_al[o] = ACC_W'($signed(bias[o])) <<< BIAS_SHIFT; // to product fraction.
      end else begin
        bias_al[o] = '0;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= CORE_ACC;
      beat_q  <= '0;
      for (int o = 0; o < UNROLL_OUT_C; o++) begin
        acc_q[o] <= '0;
      end
    end else begin
      if (fire && last_beat) begin
        state_q <= CORE_HOLD;
      end else if (data_out_ready) begin
        state_q <= CORE_ACC;
      end
      if (fire) begin
        beat_q <= last_beat ? '0 : beat_q + 1'b1;
        for (int o = 0; o < UNROLL_OUT_C; o++) begin
          acc_q[o] <= last_beat ? '0 : acc_q[o] + dot[o];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire && last_beat) begin
      for (int o = 0; o < UNROLL_OUT_C; o++) begin
        hold_q[o] <= acc_q[o] + dot[o] + bias_al[o];
      end
    end
  end

endmodule

/* fixed_rounding.sv */
`timescale 1ns/1ps
module fixed_rounding #(
  parameter int IN_SIZE        = 2,
  parameter int IN_WIDTH       = 23,
  parameter int IN_FRAC_WIDTH  = 7,
  parameter int OUT_WIDTH      = 8,
  parameter int OUT_FRAC_WIDTH = 4
) (
  input  logic [IN_WIDTH-1:0]  data_in [IN_SIZE-1:0],
  output logic [OUT_WIDTH-1:0] data_out [IN_SIZE-1:0]
);

  localparam int SHIFT = IN_FRAC_WIDTH - OUT_FRAC_WIDTH;
  localparam logic signed [IN_WIDTH:0] HALF    = (SHIFT > 0) ? (1 << (SHIFT - 1)) : 0;
  localparam logic signed [IN_WIDTH:0] MAX_OUT = (1 << (OUT_WIDTH - 1)) - 1;
  localparam logic signed [IN_WIDTH:0] MIN_OUT = -(1 << (OUT_WIDTH - 1));

  always_comb begin
    logic signed [IN_WIDTH:0] ext;
    logic signed [IN_WIDTH:0] shifted;
    for (int i = 0; i < IN_SIZE; i++) begin
      ext     = $signed({data_in[i][IN_WIDTH-1], data_in[i]}); // one guard bit for the add.
      shifted = (ext + HALF) >>> SHIFT;
      if (shifted > MAX_OUT) begin
        data_out[i] = MAX_OUT[OUT_WIDTH-1:0];
      end else if (shifted < MIN_OUT) begin
        data_out[i] = MIN_OUT[OUT_WIDTH-1:0];
      end else begin
        data_out[i] = shifted[OUT_WIDTH-1:0];
      end
    end
  end

endmodule

/* convolution.sv */
`timescale 1ns/1ps
module convolution #(
  parameter int DATA_W            = conv_fmt_pkg::DATA_W,
  parameter int DATA_FRAC         = conv_fmt_pkg::DATA_FRAC,
  parameter int WEIGHT_W          = conv_fmt_pkg::WEIGHT_W,
  parameter int WEIGHT_FRAC       = conv_fmt_pkg::WEIGHT_FRAC,
  parameter int BIAS_W            = conv_fmt_pkg::BIAS_W,
  parameter int BIAS_FRAC         = conv_fmt_pkg::BIAS_FRAC,
  parameter int OUT_W             = conv_fmt_pkg::OUT_W,
  parameter int OUT_FRAC          = conv_fmt_pkg::OUT_FRAC,
  parameter int IN_X              = 4,
  parameter int IN_Y              = 3,
  parameter int IN_C              = 4,
  parameter int UNROLL_IN_C       = 2,
  parameter int KERNEL_X          = 3,
  parameter int KERNEL_Y          = 3,
  parameter int PADDING_X         = 1,
  parameter int PADDING_Y         = 1,
  parameter int UNROLL_KERNEL_OUT = 6,
  parameter int UNROLL_OUT_C      = 2,
  parameter int HAS_BIAS          = 1
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [DATA_W-1:0]   data_in [UNROLL_IN_C-1:0],
  input  logic                data_in_valid,
  output logic                data_in_ready,
  input  logic [WEIGHT_W-1:0] weight [UNROLL_OUT_C*UNROLL_KERNEL_OUT-1:0],
  input  logic                weight_valid,
  output logic                weight_ready,
  input  logic [BIAS_W-1:0]   bias [UNROLL_OUT_C-1:0],
  input  logic                bias_valid,
  output logic                bias_ready,
  output logic [OUT_W-1:0]    data_out [UNROLL_OUT_C-1:0],
  output logic                data_out_valid,
  input  logic                data_out_ready
);

  localparam int NUM    = KERNEL_X * KERNEL_Y * UNROLL_IN_C;
  localparam int TAPS   = KERNEL_X * KERNEL_Y;
  localparam int BEAT_W = UNROLL_IN_C * DATA_W;
  localparam int ACC_W  = DATA_W + WEIGHT_W + $clog2(KERNEL_X * KERNEL_Y * IN_C) + 1;

  logic [BEAT_W-1:0] beat_in;
  logic [BEAT_W-1:0] win_packed [TAPS-1:0];
  logic [DATA_W-1:0] win [NUM-1:0];
  logic              win_valid;
  logic              win_ready;
  logic [DATA_W-1:0] chunk [UNROLL_KERNEL_OUT-1:0];
  logic              chunk_valid;
  logic              chunk_ready;
  logic [ACC_W-1:0]  acc_out [UNROLL_OUT_C-1:0];

  for (genvar c = 0; c < UNROLL_IN_C; c++) begin : g_pack
    assign beat_in[c*DATA_W +: DATA_W] = data_in[c];
  end

  // element index is tap * UNROLL_IN_C + channel.
  for (genvar k = 0; k < TAPS; k++) begin : g_tap
    for (genvar c = 0; c < UNROLL_IN_C; c++) begin : g_ch
      assign win[k*UNROLL_IN_C+c] = win_packed[k][c*DATA_W +: DATA_W];
    end
  end

  sliding_window #(
    .DATA_W      (DATA_W),
    .IN_X        (IN_X),
    .IN_Y        (IN_Y),
    .IN_C        (IN_C),
    .UNROLL_IN_C (UNROLL_IN_C),
    .KERNEL_X    (KERNEL_X),
    .KERNEL_Y    (KERNEL_Y),
    .PADDING_X   (PADDING_X),
    .PADDING_Y   (PADDING_Y)
  ) u_window (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (beat_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (win_packed),
    .data_out_valid (win_valid),
    .data_out_ready (win_ready)
  );

  roller #(
    .DATA_W   (DATA_W),
    .NUM      (NUM),
    .ROLL_NUM (UNROLL_KERNEL_OUT)
  ) u_roller (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (win),
    .data_in_valid  (win_valid),
    .data_in_ready  (win_ready),
    .data_out       (chunk),
    .data_out_valid (chunk_valid),
    .data_out_ready (chunk_ready)
  );

  conv_compute_core #(
    .DATA_W            (DATA_W),
    .DATA_FRAC         (DATA_FRAC),
    .WEIGHT_W          (WEIGHT_W),
    .WEIGHT_FRAC       (WEIGHT_FRAC),
    .BIAS_W            (BIAS_W),
    .BIAS_FRAC         (BIAS_FRAC),
    .IN_C              (IN_C),
    .UNROLL_IN_C       (UNROLL_IN_C),
    .KERNEL_X          (KERNEL_X),
    .KERNEL_Y          (KERNEL_Y),
    .UNROLL_KERNEL_OUT (UNROLL_KERNEL_OUT),
    .UNROLL_OUT_C      (UNROLL_OUT_C),
    .HAS_BIAS          (HAS_BIAS)
  ) u_core (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_in        (chunk),
    .data_in_valid  (chunk_valid),
    .data_in_ready  (chunk_ready),
    .weight         (weight),
    .weight_valid   (weight_valid),
    .weight_ready   (weight_ready),
    .bias           (bias),
    .bias_valid     (bias_valid),
    .bias_ready     (bias_ready),
    .data_out       (acc_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  fixed_rounding #(
    .IN_SIZE        (UNROLL_OUT_C),
    .IN_WIDTH       (ACC_W),
    .IN_FRAC_WIDTH  (DATA_FRAC + WEIGHT_FRAC),
    .OUT_WIDTH      (OUT_W),
    .OUT_FRAC_WIDTH (OUT_FRAC)
  ) u_round (
    .data_in  (acc_out),
    .data_out (data_out)
  );

endmodule

/* tb_convolution.sv */
`timescale 1ns/1ps
module tb_convolution;
  import conv_fmt_pkg::*;

  localparam int IN_X = 4;
  localparam int IN_Y = 3;
  localparam int IN_C = 4;
  localparam int UIC = 2;
  localparam int KX = 3;
  localparam int KY = 3;
  localparam int PX = 1;
  localparam int PY = 1;
  localparam int UKO = 6;
  localparam int UOC = 2;
  localparam int OUT_X = IN_X - KX + 2 * PX + 1;
  localparam int OUT_Y = IN_Y - KY + 2 * PY + 1;
  localparam int CHG = IN_C / UIC;
  localparam int NUM = KX * KY * UIC;
  localparam int CHUNKS = NUM / UKO;
  localparam int BEATS = IN_X * IN_Y * CHG;
  localparam int POS = OUT_X * OUT_Y;
  localparam int WBEATS = CHUNKS * CHG;
  localparam int WN = UOC * UKO;
  localparam int MAX_IMG = 3;
  localparam int HALF_N = (PY * KX + PX) * UIC; // channel 0 of the centre tap.
  localparam int CLK_PERIOD = 8;
  localparam int TOTAL_IMAGES = 7;
  localparam int WATCHDOG_NS = TOTAL_IMAGES * (BEATS + WBEATS * POS) * 8 * CLK_PERIOD;
  localparam logic [31:0] SEED = 32'ha51e_bc2b;

  logic clk;
  logic arst_n;
  logic [DATA_W-1:0] data_in [UIC-1:0];
  logic data_in_valid;
  logic data_in_ready;
  logic [WEIGHT_W-1:0] weight [WN-1:0];
  logic weight_valid;
  logic weight_ready;
  logic [BIAS_W-1:0] bias [UOC-1:0];
  logic bias_valid;
  logic bias_ready;
  logic [OUT_W-1:0] data_out [UOC-1:0];
  logic data_out_valid;
  logic data_out_ready;

  logic [DATA_W-1:0] pix_mem [MAX_IMG][BEATS][UIC];
  logic [WEIGHT_W-1:0] wt_mem [MAX_IMG][POS][WBEATS][WN];
  logic [BIAS_W-1:0] bias_mem [MAX_IMG][UOC];
  logic [UOC*OUT_W-1:0] exp_q [$];
  logic [31:0] rng_main;
  logic [31:0] rng_px;
  logic [31:0] rng_wt;
  logic [31:0] rng_bs;
  logic [31:0] rng_out;
  int errors = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int ready_back = 0;

  convolution #(
    .IN_X (IN_X), .IN_Y (IN_Y), .IN_C (IN_C), .UNROLL_IN_C (UIC),
    .KERNEL_X (KX), .KERNEL_Y (KY), .PADDING_X (PX), .PADDING_Y (PY),
    .UNROLL_KERNEL_OUT (UKO), .UNROLL_OUT_C (UOC), .HAS_BIAS (1)
  ) dut0 (
    .clk (clk), .arst_n (arst_n),
    .data_in (data_in), .data_in_valid (data_in_valid), .data_in_ready (data_in_ready),
    .weight (weight), .weight_valid (weight_valid), .weight_ready (weight_ready),
    .bias (bias), .bias_valid (bias_valid), .bias_ready (bias_ready),
    .data_out (data_out), .data_out_valid (data_out_valid), .data_out_ready (data_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error: %s expected %0h got %0h at %0t", name, exp, act, $time);
      errors++;
    end
  endtask

  // reference result of one output channel.
  function automatic logic [OUT_W-1:0] model_out(input int i, input int oy, input int ox,
                                                 input int o);
    int sum;
    int k;
    int iy;
    int ix;
    int dv;
    int wv;
    int sh;
    sum = 0;
    for (int g = 0; g < CHG; g++) begin
      for (int n = 0; n < NUM; n++) begin
        k = n / UIC;
        iy = oy + k / KX - PY;
        ix = ox + k % KX - PX;
        dv = 0;
        if (iy >= 0 && iy < IN_Y && ix >= 0 && ix < IN_X) begin
          dv = $signed(pix_mem[i][(iy * IN_X + ix) * CHG + g][n % UIC]);
        end
        wv = $signed(wt_mem[i][oy * OUT_X + ox][g * CHUNKS + n / UKO][o * UKO + n % UKO]);
        sum += dv * wv;
      end
    end
    sum += int'($signed(bias_mem[i][o])) * (1 << (DATA_FRAC + WEIGHT_FRAC - BIAS_FRAC));
    sh = DATA_FRAC + WEIGHT_FRAC - OUT_FRAC;
    sum = (sum + (1 << (sh - 1))) >>> sh;
    if (sum > (1 << (OUT_W - 1)) - 1) sum = (1 << (OUT_W - 1)) - 1;
    if (sum < -(1 << (OUT_W - 1))) sum = -(1 << (OUT_W - 1));
    return OUT_W'(sum);
  endfunction

  // mode 0 random, 1 near full scale, 2 half-step rounding.
  task automatic fill_image(input int slot, input int mode);
    int o;
    int e;
    for (int b = 0; b < BEATS; b++) begin
      for (int c = 0; c < UIC; c++) begin
        rng_main = xorshift(rng_main);
        case (mode)
          0: pix_mem[slot][b][c] = {{2{rng_main[5]}}, rng_main[5:0]};
          1: pix_mem[slot][b][c] = 8'h7f - rng_main[0];
          default: pix_mem[slot][b][c] = 8'h01;
        endcase
      end
    end
    for (int p = 0; p < POS; p++) begin
      for (int b = 0; b < WBEATS; b++) begin
        for (int k = 0; k < WN; k++) begin
          o = k / UKO;
          e = k % UKO;
          rng_main = xorshift(rng_main);
          case (mode)
            0: wt_mem[slot][p][b][k] = {{3{rng_main[12]}}, rng_main[12:8]};
            1: wt_mem[slot][p][b][k] = (o == 0) ? 8'h7f : 8'h80;
            default: wt_mem[slot][p][b][k] =
                (b == HALF_N / UKO && e == HALF_N % UKO) ? ((o == 0) ? 8'h04 : 8'hfc) : 8'h00;
          endcase
        end
      end
    end
    for (int j = 0; j < UOC; j++) begin
      rng_main = xorshift(rng_main);
      bias_mem[slot][j] = (mode == 2) ? 8'h00 : rng_main[7:0];
    end
  endtask

  task automatic drive_pixels(input int n, input int gap_pct);
    for (int i = 0; i < n; i++) begin
      for (int b = 0; b < BEATS; b++) begin
        @(posedge clk);
        rng_px = xorshift(rng_px);
        while ((rng_px % 100) < gap_pct) begin
          data_in_valid <= 1'b0;
          @(posedge clk);
          rng_px = xorshift(rng_px);
        end
        for (int c = 0; c < UIC; c++) data_in[c] <= pix_mem[i][b][c];
        data_in_valid <= 1'b1;
        @(negedge clk);
        while (!data_in_ready) @(negedge clk);
      end
      @(posedge clk);
      data_in_valid <= 1'b0;
      @(negedge clk);
      if (!data_in_ready) begin
        while (!data_in_ready) @(negedge clk); // windows of this image done.
        ready_back++;
      end
    end
  endtask

  task automatic drive_weights(input int n, input int gap_pct);
    for (int i = 0; i < n; i++) begin
      for (int p = 0; p < POS; p++) begin
        for (int b = 0; b < WBEATS; b++) begin
          @(posedge clk);
          rng_wt = xorshift(rng_wt);
          while ((rng_wt % 100) < gap_pct) begin
            weight_valid <= 1'b0;
            @(posedge clk);
            rng_wt = xorshift(rng_wt);
          end
          for (int k = 0; k < WN; k++) weight[k] <= wt_mem[i][p][b][k];
          weight_valid <= 1'b1;
          @(negedge clk);
          while (!weight_ready) @(negedge clk);
        end
      end
    end
    @(posedge clk);
    weight_valid <= 1'b0;
  endtask

  task automatic drive_bias(input int n, input int gap_pct);
    for (int i = 0; i < n; i++) begin
      for (int p = 0; p < POS; p++) begin
        @(posedge clk);
        rng_bs = xorshift(rng_bs);
        while ((rng_bs % 100) < gap_pct) begin
          bias_valid <= 1'b0;
          @(posedge clk);
          rng_bs = xorshift(rng_bs);
        end
        for (int j = 0; j < UOC; j++) bias[j] <= bias_mem[i][j];
        bias_valid <= 1'b1;
        @(negedge clk);
        while (!bias_ready) @(negedge clk);
      end
    end
    @(posedge clk);
    bias_valid <= 1'b0;
  endtask

  task automatic collect(input int total, input int stall_pct);
    int got = 0;
    logic [UOC*OUT_W-1:0] exp;
    while (got < total) begin
      @(posedge clk);
      rng_out = xorshift(rng_out);
      data_out_ready <= ((rng_out % 100) >= stall_pct);
      @(negedge clk);
      if (data_out_valid && data_out_ready) begin
        exp = exp_q.pop_front();
        for (int o = 0; o < UOC; o++) begin
          check($sformatf("data_out[%0d]", o), exp[o*OUT_W +: OUT_W], data_out[o]);
        end
        got++;
      end
    end
    @(posedge clk);
    data_out_ready <= 1'b1;
  endtask

  task automatic run_images(input int n, input int gap_pct, input int stall_pct);
    bit extra;
    extra = 1'b0;
    exp_q.delete();
    ready_back = 0;
    for (int i = 0; i < n; i++) begin
      for (int oy = 0; oy < OUT_Y; oy++) begin
        for (int ox = 0; ox < OUT_X; ox++) begin
          exp_q.push_back({model_out(i, oy, ox, 1), model_out(i, oy, ox, 0)});
        end
      end
    end
    fork
      drive_pixels(n, gap_pct);
      drive_weights(n, gap_pct);
      drive_bias(n, gap_pct);
      collect(n * POS, stall_pct);
    join
    repeat (20) begin
      @(negedge clk);
      if (data_out_valid) extra = 1'b1;
    end
    if (extra) begin
      $display("an output appeared after the last expected one");
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
      tests_bad++;
    end
  endtask

  initial begin
    int e0;
    rng_main = SEED;
    rng_px = SEED ^ 32'h1357_9bdf;
    rng_wt = SEED ^ 32'h2468_ace0;
    rng_bs = SEED ^ 32'h0f0f_3c3c;
    rng_out = SEED ^ 32'h5a5a_7777;
    arst_n = 1'b0;
    data_in_valid = 1'b0;
    weight_valid = 1'b0;
    bias_valid = 1'b0;
    data_out_ready = 1'b0;
    for (int c = 0; c < UIC; c++) data_in[c] = '0;
    for (int k = 0; k < WN; k++) weight[k] = '0;
    for (int j = 0; j < UOC; j++) bias[j] = '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    e0 = errors;
    @(negedge clk);
    check("data_out_valid", 0, data_out_valid);
    check("data_in_ready", 1, data_in_ready);
    end_test("reset", e0);

    e0 = errors;
    fill_image(0, 0);
    run_images(1, 10, 10);
    end_test("single image", e0);

    e0 = errors;
    fill_image(0, 1);
    fill_image(1, 2);
    run_images(2, 10, 10);
    end_test("saturation and rounding", e0);

    e0 = errors;
    fill_image(0, 0);
    run_images(1, 50, 60);
    end_test("back-pressure and gaps", e0);

    e0 = errors;
    for (int i = 0; i < 3; i++) fill_image(i, 0);
    run_images(3, 20, 30);
    check("images reloaded", 3, ready_back);
    end_test("three images", e0);

    $display("tests run %0d, tests with errors %0d, errors %0d", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    if (data_in_valid && !data_in_ready) begin
      $display("timeout: the pixel input stream stalled");
    end else if (weight_valid && !weight_ready) begin
      $display("timeout: the weight stream stalled");
    end else if (bias_valid && !bias_ready) begin
      $display("timeout: the bias stream stalled");
    end else begin
      $display("timeout: the output stream stopped delivering results");
    end
    $display("sim failed");
    $finish;
  end

endmodule

/* convolution.f */
conv_fmt_pkg.sv
conv_ctrl_pkg.sv
sliding_window.sv
roller.sv
conv_compute_core.sv
fixed_rounding.sv
convolution.sv
tb_convolution.sv

/* Bender.yml */
package:
  name: convolution

sources:
  - conv_fmt_pkg.sv
  - conv_ctrl_pkg.sv
  - sliding_window.sv
  - roller.sv
  - conv_compute_core.sv
  - fixed_rounding.sv
  - convolution.sv
  - target: test
    files:
      - tb_convolution.sv
